//--- source/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// lanes per beat, must be a power of two for the adder tree
`define CONV_TIN 8

// element width of data and weights
`define CONV_DAT_DW 8

// group accumulator width
`define CONV_ACC_DW 24

// requantization shift field
`define CONV_SHIFT_DW 5

// register port
`define CONV_CSR_AW 2
`define CONV_CSR_DW 32

// register map
`define CONV_REG_CTRL 0
`define CONV_REG_SHIFT 1
`define CONV_REG_ID 2

// identification word, reads back as "CONV"
`define CONV_CORE_ID 32'h434f_4e56

`endif

//--- source/conv_pkg.sv
package conv_pkg;

`include "conv_consts.svh"

	// one signed element of a beat
	typedef logic signed [`CONV_DAT_DW-1:0] dat_t;

	// all lanes of one beat, lane 0 in the low bits
	typedef logic [`CONV_TIN*`CONV_DAT_DW-1:0] dat_vec_t;

	// running dot product of a group
	typedef logic signed [`CONV_ACC_DW-1:0] acc_t;

	// right shift applied before saturation
	typedef logic [`CONV_SHIFT_DW-1:0] shift_t;

	// register address
	typedef logic [`CONV_CSR_AW-1:0] csr_addr_t;

	// register word
	typedef logic [`CONV_CSR_DW-1:0] csr_data_t;

endpackage

//--- source/conv_csr.sv
`include "conv_consts.svh"

module conv_csr
	import conv_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	// register strobe port
	input  logic      csr_wr,
	input  logic      csr_rd,
	input  csr_addr_t csr_addr,
	input  csr_data_t csr_wdata,
	output logic      csr_rd_vld,
	output csr_data_t csr_rdata,

	// configuration to the requantizer
	output logic      relu_en,
	output logic      res_en,
	output shift_t    out_shift
);

	// readback word for the current address
	csr_data_t rd_word;

	// write decode, new values seen on the next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			relu_en   <= 1'b0;
			res_en    <= 1'b0;
			out_shift <= '0;
		end else if (csr_wr) begin
			case (csr_addr)
				csr_addr_t'(`CONV_REG_CTRL): begin
					relu_en <= csr_wdata[0];
					res_en  <= csr_wdata[1];
				end
				csr_addr_t'(`CONV_REG_SHIFT): begin
					out_shift <= csr_wdata[`CONV_SHIFT_DW-1:0];
				end
				default: begin
					// ID is read only, remaining addresses unused
				end
			endcase
		end
	end

	// read mux, unused bits stay zero
	always_comb begin
		rd_word = '0;
		case (csr_addr)
			csr_addr_t'(`CONV_REG_CTRL): begin
				rd_word[0] = relu_en;
				rd_word[1] = res_en;
			end
			csr_addr_t'(`CONV_REG_SHIFT): begin
				rd_word[`CONV_SHIFT_DW-1:0] = out_shift;
			end
			csr_addr_t'(`CONV_REG_ID): begin
				rd_word = `CONV_CORE_ID;
			end
			default: begin
				rd_word = '0;
			end
		endcase
	end

	// read response one cycle after the strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			csr_rd_vld <= 1'b0;
		end else begin
			csr_rd_vld <= csr_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (csr_rd) begin
			csr_rdata <= rd_word;
		end
	end

endmodule

//--- source/conv_mac.sv
`include "conv_consts.svh"

module conv_mac
	import conv_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	// input beats
	input  logic     dat_vld,
	input  dat_vec_t dat,
	input  dat_vec_t wt,
	input  logic     last,
	input  dat_t     res,

	// finished group sums
	output logic     acc_vld,
	output acc_t     acc,
	output dat_t     acc_res
);

	localparam int TIN = `CONV_TIN;
	localparam int DAT_DW = `CONV_DAT_DW;
	localparam int PROD_DW = 2 * DAT_DW;
	// each tree level adds one bit of growth
	localparam int TREE_DW = PROD_DW + $clog2(TIN);

	// stage one, lane products
	logic signed [PROD_DW-1:0] prod_q [TIN];
	logic                      s1_vld;
	logic                      s1_last;
	dat_t                      s1_res;

	// adder tree nodes, heap order with the root at 1
	logic signed [TREE_DW-1:0] tree [1:2*TIN-1];

	// stage two, beat sum
	logic                      s2_vld;
	logic                      s2_last;
	acc_t                      s2_sum;
	dat_t                      s2_res;

	// high while a group has beats but no last yet
	logic                      grp_open;

	// stage one control
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_vld <= 1'b0;
		end else begin
			s1_vld <= dat_vld;
		end
	end

	// signed multiply per lane
	always_ff @(posedge clk) begin
		for (int i = 0; i < TIN; i++) begin
			prod_q[i] <= dat_t'(dat[i*DAT_DW +: DAT_DW])
				* dat_t'(wt[i*DAT_DW +: DAT_DW]);
		end
		s1_last <= last;
		s1_res  <= res;
	end

	// leaves are the products, each node sums its two children
	always_comb begin
		for (int i = 0; i < TIN; i++) begin
			tree[TIN+i] = prod_q[i];
		end
		for (int n = TIN - 1; n >= 1; n--) begin
			tree[n] = tree[2*n] + tree[2*n+1];
		end
	end

	// stage two control
	always_ff @(posedge clk) begin
		if (rst) begin
			s2_vld <= 1'b0;
		end else begin
			s2_vld <= s1_vld;
		end
	end

	// tree root widened to the accumulator
	always_ff @(posedge clk) begin
		s2_sum  <= tree[1];
		s2_last <= s1_last;
		s2_res  <= s1_res;
	end

	// stage three, group tracking and result strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			grp_open <= 1'b0;
			acc_vld  <= 1'b0;
		end else begin
			acc_vld <= s2_vld & s2_last;
			if (s2_vld) begin
				grp_open <= ~s2_last;
			end
		end
	end

	// first beat of a group restarts the sum
	always_ff @(posedge clk) begin
		if (s2_vld) begin
			if (grp_open) begin
				acc <= acc + s2_sum;
			end else begin
				acc <= s2_sum;
			end
		end
		// residual only matters on the closing beat
		if (s2_vld && s2_last) begin
			acc_res <= s2_res;
		end
	end

endmodule

//--- source/conv_requant.sv
`include "conv_consts.svh"

module conv_requant
	import conv_pkg::*;
(
	input  logic   clk,
	input  logic   rst,

	// group sums from the MAC
	input  logic   acc_vld,
	input  acc_t   acc,
	input  dat_t   acc_res,

	// configuration
	input  logic   relu_en,
	input  logic   res_en,
	input  shift_t out_shift,

	// requantized result
	output logic   out_vld,
	output dat_t   out_dat
);

	// wide enough for the largest rounding bias plus sign
	localparam int WIDE_DW = (1 << `CONV_SHIFT_DW) + 2;

	// saturation limits of a signed element
	localparam logic signed [WIDE_DW-1:0] SAT_MAX = (1 <<< (`CONV_DAT_DW - 1)) - 1;
	localparam logic signed [WIDE_DW-1:0] SAT_MIN = -(1 <<< (`CONV_DAT_DW - 1));

	logic signed [WIDE_DW-1:0] acc_wide;
	logic signed [WIDE_DW-1:0] bias;
	logic signed [WIDE_DW-1:0] shifted;
	logic signed [WIDE_DW-1:0] with_res;
	logic signed [WIDE_DW-1:0] relu_val;
	dat_t                      sat_val;

	always_comb begin
		acc_wide = acc;

		// half an LSB of the output, round half up
		bias = '0;
		if (out_shift != '0) begin
			bias[out_shift - 1'b1] = 1'b1;
		end
		shifted = (acc_wide + bias) >>> out_shift;

		// optional residual
		if (res_en) begin
			with_res = shifted + acc_res;
		end else begin
			with_res = shifted;
		end

		// optional ReLU
		if (relu_en && with_res < 0) begin
			relu_val = '0;
		end else begin
			relu_val = with_res;
		end

		// clamp to the element range
		if (relu_val > SAT_MAX) begin
			sat_val = SAT_MAX[`CONV_DAT_DW-1:0];
		end else if (relu_val < SAT_MIN) begin
			sat_val = SAT_MIN[`CONV_DAT_DW-1:0];
		end else begin
			sat_val = relu_val[`CONV_DAT_DW-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_vld <= 1'b0;
		end else begin
			out_vld <= acc_vld;
		end
	end

	// result held until the next group
	always_ff @(posedge clk) begin
		if (acc_vld) begin
			out_dat <= sat_val;
		end
	end

endmodule

//--- source/conv_core.sv
module conv_core
	import conv_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	// register strobe port
	input  logic      csr_wr,
	input  logic      csr_rd,
	input  csr_addr_t csr_addr,
	input  csr_data_t csr_wdata,
	output logic      csr_rd_vld,
	output csr_data_t csr_rdata,

	// data and weight beats
	input  logic      dat_vld,
	input  dat_vec_t  dat,
	input  dat_vec_t  wt,
	input  logic      last,
	input  dat_t      res,

	// one result per group
	output logic      out_vld,
	output dat_t      out_dat
);

	// configuration from the register block
	logic   relu_en;
	logic   res_en;
	shift_t out_shift;

	// finished sums from the MAC
	logic   acc_vld;
	acc_t   acc;
	dat_t   acc_res;

	// decode
	conv_csr u_csr (
		.clk        (clk),
		.rst        (rst),
		.csr_wr     (csr_wr),
		.csr_rd     (csr_rd),
		.csr_addr   (csr_addr),
		.csr_wdata  (csr_wdata),
		.csr_rd_vld (csr_rd_vld),
		.csr_rdata  (csr_rdata),
		.relu_en    (relu_en),
		.res_en     (res_en),
		.out_shift  (out_shift)
	);

	// execute, three cycles from beat to group sum
	conv_mac u_mac (
		.clk     (clk),
		.rst     (rst),
		.dat_vld (dat_vld),
		.dat     (dat),
		.wt      (wt),
		.last    (last),
		.res     (res),
		.acc_vld (acc_vld),
		.acc     (acc),
		.acc_res (acc_res)
	);

	// result, one more cycle to the output
	conv_requant u_requant (
		.clk       (clk),
		.rst       (rst),
		.acc_vld   (acc_vld),
		.acc       (acc),
		.acc_res   (acc_res),
		.relu_en   (relu_en),
		.res_en    (res_en),
		.out_shift (out_shift),
		.out_vld   (out_vld),
		.out_dat   (out_dat)
	);

endmodule

//--- tests/conv_core_assertions.sv
module conv_core_assertions (
	input logic clk,
	input logic rst,
	input logic dat_vld,
	input logic last,
	input logic out_vld,
	input logic csr_rd,
	input logic csr_rd_vld
);

	// read by the testbench at the end of the run
	int err_count = 0;

	// one result four cycles after each closing beat
	assert property (@(posedge clk) disable iff (rst) out_vld == $past(dat_vld && last, 4))
	else begin
		err_count++;
		$error("out_vld does not follow a last beat by four cycles");
	end

	// read response exactly one cycle after the strobe
	assert property (@(posedge clk) disable iff (rst) csr_rd_vld == $past(csr_rd))
	else begin
		err_count++;
		$error("csr_rd_vld does not follow csr_rd by one cycle");
	end

	// strobes quiet while in reset
	assert property (@(posedge clk) rst |=> (!out_vld && !csr_rd_vld))
	else begin
		err_count++;
		$error("output strobe high during reset");
	end

endmodule

bind conv_core conv_core_assertions u_assertions (
	.clk        (clk),
	.rst        (rst),
	.dat_vld    (dat_vld),
	.last       (last),
	.out_vld    (out_vld),
	.csr_rd     (csr_rd),
	.csr_rd_vld (csr_rd_vld)
);

//--- tests/conv_core_tb.sv
`include "conv_consts.svh"

module conv_core_tb
	import conv_pkg::*;
;

	localparam int RESET_CYCLES = 8;
	// the directed tests take roughly this long
	localparam int TEST_CYCLES = 600;
	localparam int MAX_CYCLES = 3 * TEST_CYCLES + 200;
	localparam int DRAIN_CYCLES = 16;
	localparam int RAND_GROUPS = 24;

	// lane 0 sits in the low byte
	localparam dat_vec_t ONES = 64'h0101_0101_0101_0101;
	localparam dat_vec_t RAMP = 64'h0a09_0807_0605_0403;
	localparam dat_vec_t MIX_D = 64'hff06_02fc_0105_fe03;
	localparam dat_vec_t MIX_W = 64'h0702_fb01_04ff_0302;
	localparam dat_vec_t POS_MAX = 64'h7f7f_7f7f_7f7f_7f7f;
	localparam dat_vec_t NEG_MAX = 64'h8080_8080_8080_8080;

	logic clk;
	logic rst;
	logic csr_wr;
	logic csr_rd;
	csr_addr_t csr_addr;
	csr_data_t csr_wdata;
	logic csr_rd_vld;
	csr_data_t csr_rdata;
	logic dat_vld;
	dat_vec_t dat;
	dat_vec_t wt;
	logic last;
	dat_t res;
	logic out_vld;
	dat_t out_dat;

	// reference model state
	bit m_relu;
	bit m_res;
	shift_t m_shift;
	longint grp_sum;
	dat_t exp_q[$];
	dat_t exp_v;

	integer seed = 88;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int out_count = 0;
	int cycles = 0;

	conv_core UUT (
		.clk        (clk),
		.rst        (rst),
		.csr_wr     (csr_wr),
		.csr_rd     (csr_rd),
		.csr_addr   (csr_addr),
		.csr_wdata  (csr_wdata),
		.csr_rd_vld (csr_rd_vld),
		.csr_rdata  (csr_rdata),
		.dat_vld    (dat_vld),
		.dat        (dat),
		.wt         (wt),
		.last       (last),
		.res        (res),
		.out_vld    (out_vld),
		.out_dat    (out_dat)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// results are taken in order at the falling edge
	always @(negedge clk) begin
		if (!rst && out_vld) begin
			out_count = out_count + 1;
			if (exp_q.size() == 0) begin
				$display("extra output %0d at time %0t with no group pending", out_dat, $time);
				errors = errors + 1;
			end else begin
				exp_v = exp_q.pop_front();
				check_dat(out_dat, exp_v, "group result");
			end
		end
	end

	task automatic check_dat(input dat_t got, input dat_t exp, input string what);
		checks = checks + 1;
		if (got !== exp) begin
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic check_csr(input csr_data_t got, input csr_data_t exp, input string what);
		checks = checks + 1;
		if (got !== exp) begin
			$display("Fail %0t: %s reads 0x%08h, expected 0x%08h", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	// lane by lane dot product of one beat
	function automatic longint dot_product(input dat_vec_t d, input dat_vec_t w);
		longint s;
		dat_t a;
		dat_t b;
		s = 0;
		for (int i = 0; i < `CONV_TIN; i++) begin
			a = d[i*`CONV_DAT_DW +: `CONV_DAT_DW];
			b = w[i*`CONV_DAT_DW +: `CONV_DAT_DW];
			s = s + longint'(a) * longint'(b);
		end
		return s;
	endfunction

	// rounding shift, residual, ReLU, then saturation
	function automatic dat_t requantize(input longint sum, input dat_t r);
		longint v;
		v = sum;
		if (m_shift != 0) begin
			v = (v + (longint'(1) <<< (m_shift - 1))) >>> m_shift;
		end
		if (m_res) begin
			v = v + longint'(r);
		end
		if (m_relu && v < 0) begin
			v = 0;
		end
		if (v > 127) begin
			v = 127;
		end else if (v < -128) begin
			v = -128;
		end
		return dat_t'(v);
	endfunction

	task automatic write_csr(input csr_addr_t a, input csr_data_t d);
		@(posedge clk);
		csr_wr <= 1'b1;
		csr_addr <= a;
		csr_wdata <= d;
		@(posedge clk);
		csr_wr <= 1'b0;
		if (a == csr_addr_t'(`CONV_REG_CTRL)) begin
			m_relu = d[0];
			m_res = d[1];
		end else if (a == csr_addr_t'(`CONV_REG_SHIFT)) begin
			m_shift = d[4:0];
		end
	endtask

	task automatic read_check(input csr_addr_t a, input csr_data_t exp, input string what);
		int n;
		n = 0;
		@(posedge clk);
		csr_rd <= 1'b1;
		csr_addr <= a;
		@(posedge clk);
		csr_rd <= 1'b0;
		@(negedge clk);
		while (!csr_rd_vld && n < 4) begin
			@(negedge clk);
			n++;
		end
		if (!csr_rd_vld) begin
			$display("no read response for %s at time %0t", what, $time);
			errors = errors + 1;
		end else begin
			check_csr(csr_rdata, exp, what);
		end
	endtask

	task automatic send_beat(input dat_vec_t d, input dat_vec_t w, input bit l, input dat_t r);
		@(posedge clk);
		dat_vld <= 1'b1;
		dat <= d;
		wt <= w;
		last <= l;
		res <= r;
		grp_sum = grp_sum + dot_product(d, w);
		if (l) begin
			exp_q.push_back(requantize(grp_sum, r));
			grp_sum = 0;
		end
	endtask

	task automatic send_repeat(input int n, input dat_vec_t d, input dat_vec_t w, input dat_t r);
		for (int i = 0; i < n; i++) begin
			send_beat(d, w, i == n - 1, r);
		end
	endtask

	// idle the data port and wait for every pending group
	task automatic wait_outputs();
		int n;
		n = 0;
		@(posedge clk);
		dat_vld <= 1'b0;
		last <= 1'b0;
		while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected outputs never arrived by time %0t", exp_q.size(), $time);
			errors = errors + 1;
			exp_q.delete();
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic test_registers();
		int e;
		e = errors;
		read_check(csr_addr_t'(`CONV_REG_CTRL), 32'h0, "control after reset");
		read_check(csr_addr_t'(`CONV_REG_SHIFT), 32'h0, "shift after reset");
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'hffff_fffe);
		read_check(csr_addr_t'(`CONV_REG_CTRL), 32'h0000_0002, "control");
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'h0000_0003);
		read_check(csr_addr_t'(`CONV_REG_CTRL), 32'h0000_0003, "control");
		write_csr(csr_addr_t'(`CONV_REG_SHIFT), 32'hffff_ffe7);
		read_check(csr_addr_t'(`CONV_REG_SHIFT), 32'h0000_0007, "shift");
		read_check(csr_addr_t'(`CONV_REG_ID), `CONV_CORE_ID, "ID");
		write_csr(csr_addr_t'(`CONV_REG_ID), 32'h1234_5678);
		read_check(csr_addr_t'(`CONV_REG_ID), `CONV_CORE_ID, "ID after write");
		read_check(csr_addr_t'(`CONV_REG_CTRL), 32'h0000_0003, "control after ID write");
		read_check(csr_addr_t'(3), 32'h0, "unused address");
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'h0);
		write_csr(csr_addr_t'(`CONV_REG_SHIFT), 32'h0);
		finish_test("register access", e);
	endtask

	task automatic test_single_beat();
		int e;
		e = errors;
		// products 6 -6 -5 4 -4 -10 12 -7
		// residual is ignored while res_en is clear
		send_beat(MIX_D, MIX_W, 1'b1, 8'sd50);
		send_beat(ONES, RAMP, 1'b1, -8'sd20);
		send_beat(RAMP, MIX_W, 1'b1, 8'sd0);
		wait_outputs();
		finish_test("single beat", e);
	endtask

	task automatic test_accumulate();
		int e;
		e = errors;
		write_csr(csr_addr_t'(`CONV_REG_SHIFT), 32'd2);
		// 6 and -6 sit exactly on the half
		send_repeat(2, 64'h03, 64'h01, 8'sd0);
		send_repeat(2, 64'hfd, 64'h01, 8'sd0);
		send_repeat(3, POS_MAX, POS_MAX, 8'sd0);
		send_repeat(3, NEG_MAX, POS_MAX, 8'sd0);
		send_repeat(2, MIX_D, RAMP, 8'sd0);
		wait_outputs();
		write_csr(csr_addr_t'(`CONV_REG_SHIFT), 32'd0);
		finish_test("accumulate", e);
	endtask

	task automatic test_relu();
		int e;
		e = errors;
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'h1);
		send_beat(MIX_D, MIX_W, 1'b1, 8'sd0);
		send_beat(ONES, RAMP, 1'b1, 8'sd0);
		wait_outputs();
		finish_test("relu", e);
	endtask

	task automatic test_residual();
		int e;
		e = errors;
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'h2);
		send_beat(ONES, RAMP, 1'b1, -8'sd100);
		send_beat(ONES, RAMP, 1'b1, 8'sd100);
		send_beat(MIX_D, MIX_W, 1'b1, -8'sd128);
		wait_outputs();
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'h3);
		send_beat(ONES, RAMP, 1'b1, -8'sd100);
		send_beat(ONES, RAMP, 1'b1, 8'sd30);
		wait_outputs();
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'h0);
		finish_test("residual", e);
	endtask

	task automatic test_random_groups();
		int e;
		int nb;
		int first;
		dat_vec_t d;
		dat_vec_t w;
		dat_t r;
		e = errors;
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'h2);
		write_csr(csr_addr_t'(`CONV_REG_SHIFT), 32'd10);
		first = out_count;
		for (int g = 0; g < RAND_GROUPS; g++) begin
			nb = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
			for (int b = 0; b < nb; b++) begin
				d = {$random(seed), $random(seed)};
				w = {$random(seed), $random(seed)};
				r = $random(seed);
				send_beat(d, w, b == nb - 1, r);
			end
		end
		wait_outputs();
		if (out_count - first != RAND_GROUPS) begin
			$display("got %0d outputs for %0d groups", out_count - first, RAND_GROUPS);
			errors = errors + 1;
		end
		write_csr(csr_addr_t'(`CONV_REG_CTRL), 32'h0);
		write_csr(csr_addr_t'(`CONV_REG_SHIFT), 32'd0);
		finish_test("random groups", e);
	endtask

	initial begin
		rst = 1'b1;
		csr_wr = 1'b0;
		csr_rd = 1'b0;
		csr_addr = '0;
		csr_wdata = '0;
		dat_vld = 1'b0;
		dat = '0;
		wt = '0;
		last = 1'b0;
		res = '0;
		m_relu = 1'b0;
		m_res = 1'b0;
		m_shift = '0;
		grp_sum = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		test_registers();
		test_single_beat();
		test_accumulate();
		test_relu();
		test_residual();
		test_random_groups();
		errors = errors + UUT.u_assertions.err_count;
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion errors %0d",
			tests_run, tests_failed, checks, errors, UUT.u_assertions.err_count);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+source
source/conv_pkg.sv
source/conv_csr.sv
source/conv_mac.sv
source/conv_requant.sv
source/conv_core.sv
tests/conv_core_assertions.sv
tests/conv_core_tb.sv

//--- Bender.yml
package:
  name: conv_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/conv_pkg.sv
      - source/conv_csr.sv
      - source/conv_mac.sv
      - source/conv_requant.sv
      - source/conv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/conv_core_assertions.sv
      - tests/conv_core_tb.sv
